/* vlog.f */
ls_types_pkg.sv
ls_bus_pkg.sv
ls_sequencer.sv
ls_beat_counter.sv
ls_addr_unit.sv
ls_byte_lane.sv
ls_byte_ram.sv
ls_unit_top.sv
ls_unit_properties.sv
tb_ls_unit.sv

/* tb_ls_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the load/store unit: random commands checked
// against a byte memory and buffer pointer model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_ls_unit;

    localparam int timeout = 100;            // cycles allowed per wait

    logic                     ctl = 1'b0;
    logic                     rst_n;
    logic                     cmd_valid;
    ls_types_pkg::ls_cmd_t    cmd;
    logic                     cmd_ready;
    logic                     done;
    ls_types_pkg::ls_result_t result;

    logic [31:0]         rng_state = 32'd60369;
    logic [7:0]          mem_model [4096];   // mirrors the 12-bit RAM
    ls_types_pkg::addr_t ibuf_model = 'h400;
    ls_types_pkg::addr_t obuf_model = 'h500;

    ls_unit_top u_dut (
        .ctl(ctl), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd(cmd),
        .cmd_ready(cmd_ready), .done(done), .result(result)
    );

    always #50 ctl = ~ctl;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [31:0] rand_below(input int unsigned n);
        return (next_rand() >> 8) % n;       // low lcg bits are weak
    endfunction

    function automatic logic [7:0] peek(input ls_types_pkg::addr_t a);
        return mem_model[a[11:0]];
    endfunction

    function automatic void poke(input ls_types_pkg::addr_t a, input logic [7:0] b);
        mem_model[a[11:0]] = b;
    endfunction

    function automatic ls_types_pkg::ls_cmd_t make_cmd(input ls_types_pkg::ls_op_e op,
                                                       input ls_types_pkg::word_t tos,
                                                       input ls_types_pkg::word_t nos);
        ls_types_pkg::ls_cmd_t c;
        c.op  = op;
        c.tos = tos;
        c.nos = nos;
        return c;
    endfunction

    // expected result, and the memory and pointer effects of one command
    function automatic ls_types_pkg::ls_result_t predict(input ls_types_pkg::ls_cmd_t c);
        ls_types_pkg::ls_result_t r;
        ls_types_pkg::word_t      w;
        int                       n;
        int                       i;
        case (c.op)
            ls_types_pkg::op_iaload, ls_types_pkg::op_iastore: n = 4;
            ls_types_pkg::op_saload, ls_types_pkg::op_sastore: n = 2;
            default:                                            n = 1;
        endcase
        w = '0;
        for (i = 0; i < n; i++)
            w = {w[23:0], peek(c.tos[16:0] + i)};   // first byte is the msb
        r.op  = c.op;
        r.tos = c.nos;                       // stores and put pop
        case (c.op)
            ls_types_pkg::op_iaload: r.tos = w;
            ls_types_pkg::op_saload: r.tos = {{16{w[15]}}, w[15:0]};
            ls_types_pkg::op_baload: r.tos = {{24{w[7]}}, w[7:0]};
            ls_types_pkg::op_get: begin
                r.tos      = {24'd0, peek(ibuf_model)};
                ibuf_model = ibuf_model + 1'b1;
            end
            ls_types_pkg::op_put: begin
                poke(obuf_model, c.tos[7:0]);
                obuf_model = obuf_model + 1'b1;
            end
            default: begin
                for (i = 0; i < n; i++)
                    poke(c.nos[16:0] + i, c.tos[8*(n-1-i) +: 8]);
            end
        endcase
        return r;
    endfunction

    task automatic stop_run();
        $display("Done: errors found");
        $fatal(1, "stopped on first error");
    endtask

    task automatic check_result(input ls_types_pkg::ls_result_t got,
                                input ls_types_pkg::ls_result_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t result: got tos=%h op=%s expected tos=%h op=%s",
                     $time, got.tos, got.op.name(), exp.tos, exp.op.name());
            stop_run();
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t cmd_ready: got %b expected %b", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic check_done(input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t done: got %b expected %b", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (cmd_ready !== 1'b1) begin
            @(negedge ctl);
            n++;
            if (n > timeout) begin
                $display("timeout: cmd_ready stayed low for %0d cycles", timeout);
                stop_run();
            end
        end
    endtask

    // cmd_ready must stay low from acceptance through the done cycle
    task automatic wait_done();
        int n;
        n = 0;
        check_ready(cmd_ready, 1'b0);
        while (done !== 1'b1) begin
            @(negedge ctl);
            check_ready(cmd_ready, 1'b0);
            n++;
            if (n > timeout) begin
                $display("timeout: no done within %0d cycles of acceptance", timeout);
                stop_run();
            end
        end
    endtask

    task automatic run_cmd(input ls_types_pkg::ls_cmd_t c);
        ls_types_pkg::ls_result_t exp;
        exp       = predict(c);
        cmd       = c;
        cmd_valid = 1'b1;
        wait_ready();
        @(negedge ctl);                      // taken on the rising edge before
        cmd_valid = 1'b0;
        wait_done();
        check_result(result, exp);
    endtask

    // second command waits with cmd_valid high while the first runs
    task automatic run_overlap(input ls_types_pkg::ls_cmd_t a, input ls_types_pkg::ls_cmd_t b);
        ls_types_pkg::ls_result_t exp_a;
        ls_types_pkg::ls_result_t exp_b;
        exp_a     = predict(a);
        exp_b     = predict(b);
        cmd       = a;
        cmd_valid = 1'b1;
        wait_ready();
        @(negedge ctl);
        cmd = b;                             // valid stays high
        wait_done();
        check_result(result, exp_a);
        wait_ready();
        @(negedge ctl);
        cmd_valid = 1'b0;
        wait_done();
        check_result(result, exp_b);
        repeat (3) begin
            @(negedge ctl);
            check_ready(cmd_ready, 1'b1);    // not taken a second time
            check_done(done, 1'b0);
        end
    endtask

    initial begin
        ls_types_pkg::ls_op_e op;
        logic [31:0]          a;
        logic [31:0]          d;
        int                   i;
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        repeat (5) @(negedge ctl);
        rst_n = 1'b1;
        repeat (4) begin
            check_ready(cmd_ready, 1'b1);
            check_done(done, 1'b0);
            @(negedge ctl);
        end
        // known bytes everywhere a random load can reach
        for (i = 0; i < 'h3F4; i += 4)
            run_cmd(make_cmd(ls_types_pkg::op_iastore, next_rand(), i));
        repeat (200) begin
            op = ls_types_pkg::ls_op_e'(rand_below(6));
            a  = rand_below('h3F1);
            d  = next_rand();
            if (op <= ls_types_pkg::op_baload)
                run_cmd(make_cmd(op, a, d));
            else
                run_cmd(make_cmd(op, d, a));
        end
        // negative byte and halfword, then a byte inside a word
        a = rand_below('h3F1);
        run_cmd(make_cmd(ls_types_pkg::op_bastore, next_rand() | 'h80, a));
        run_cmd(make_cmd(ls_types_pkg::op_baload, a, 0));
        a = rand_below('h3F1);
        run_cmd(make_cmd(ls_types_pkg::op_sastore, next_rand() | 'h8000, a));
        run_cmd(make_cmd(ls_types_pkg::op_saload, a, 0));
        a = rand_below('h3EE);
        run_cmd(make_cmd(ls_types_pkg::op_iastore, next_rand(), a));
        run_cmd(make_cmd(ls_types_pkg::op_bastore, next_rand(), a + 2));
        run_cmd(make_cmd(ls_types_pkg::op_iaload, a, 0));
        // input buffer
        for (i = 0; i < 8; i++)
            run_cmd(make_cmd(ls_types_pkg::op_bastore, next_rand() | (i << 7), 'h400 + i));
        repeat (8) run_cmd(make_cmd(ls_types_pkg::op_get, next_rand(), next_rand()));
        // output buffer, read back byte by byte
        repeat (8) run_cmd(make_cmd(ls_types_pkg::op_put, next_rand(), next_rand()));
        for (i = 0; i < 8; i++)
            run_cmd(make_cmd(ls_types_pkg::op_baload, 'h500 + i, 0));
        a = rand_below('h3F1);
        run_overlap(make_cmd(ls_types_pkg::op_sastore, next_rand(), a),
                    make_cmd(ls_types_pkg::op_saload, a, 0));
        if (u_dut.u_props.fail_count != 0) begin
            $display("%0d bus or handshake assertions failed", u_dut.u_props.fail_count);
            stop_run();
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* ls_unit_properties.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus and command handshake rules of the load/store unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ls_unit_properties (
    input logic ctl,
    input logic rst_n,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic cmd_ready,
    input logic done
);

    int fail_count = 0;                      // failed assertions so far

    a_stb_cyc: assert property (@(posedge ctl) disable iff (!rst_n) stb |-> cyc)
        else begin
            $error("stb high without cyc");
            fail_count++;
        end

    a_ack_single: assert property (@(posedge ctl) disable iff (!rst_n) ack |=> !ack)
        else begin
            $error("ack high two cycles in a row");
            fail_count++;
        end

    // no new command while a bus cycle runs
    a_busy_ready: assert property (@(posedge ctl) disable iff (!rst_n) cyc |-> !cmd_ready)
        else begin
            $error("cmd_ready high during a bus cycle");
            fail_count++;
        end

    a_done_pulse: assert property (@(posedge ctl) disable iff (!rst_n) done |=> !done)
        else begin
            $error("done longer than one cycle");
            fail_count++;
        end

endmodule

bind ls_unit_top ls_unit_properties u_props (
    .ctl(ctl), .rst_n(rst_n), .cyc(bus_req.cyc), .stb(bus_req.stb),
    .ack(bus_rsp.ack), .cmd_ready(cmd_ready), .done(done)
);

`default_nettype wire

/* ls_unit_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load/store unit top: sequencer, beat counter, address unit,
// byte lanes and the byte RAM on one wishbone bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ls_unit_top #(
    parameter ls_types_pkg::addr_t tib_base  = 'h400,
    parameter ls_types_pkg::addr_t obuf_base = 'h500,
    parameter int                  mem_aw    = 12
) (
    input  logic                     ctl,
    input  logic                     rst_n,
    input  logic                     cmd_valid,
    input  ls_types_pkg::ls_cmd_t    cmd,
    output logic                     cmd_ready,
    output logic                     done,
    output ls_types_pkg::ls_result_t result
);

    ls_bus_pkg::wb_req_t  bus_req;
    ls_bus_pkg::wb_rsp_t  bus_rsp;
    ls_types_pkg::ls_op_e op;                // live op for all units
    logic                 start;
    logic                 last;
    logic [2:0]           remaining;

    ls_sequencer u_seq (
        .ctl(ctl), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd(cmd),
        .cmd_ready(cmd_ready), .ack(bus_rsp.ack), .last(last),
        .cyc(bus_req.cyc), .stb(bus_req.stb), .we(bus_req.we),
        .start(start), .op(op), .done(done)
    );

    ls_beat_counter u_cnt (
        .ctl(ctl), .rst_n(rst_n), .start(start), .op(op),
        .ack(bus_rsp.ack), .remaining(remaining), .last(last)
    );

    ls_addr_unit #(.tib_base(tib_base), .obuf_base(obuf_base)) u_addr (
        .ctl(ctl), .rst_n(rst_n), .start(start), .op(op), .cmd(cmd),
        .ack(bus_rsp.ack), .done(done), .adr(bus_req.adr)
    );

    ls_byte_lane u_lane (
        .ctl(ctl), .rst_n(rst_n), .start(start), .op(op), .cmd(cmd),
        .ack(bus_rsp.ack), .dat_r(bus_rsp.dat_r), .remaining(remaining),
        .dat_w(bus_req.dat_w), .result(result)
    );

    ls_byte_ram #(.mem_aw(mem_aw)) u_ram (
        .ctl(ctl), .rst_n(rst_n), .req(bus_req), .rsp(bus_rsp)
    );

endmodule

`default_nettype wire

/* ls_byte_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte RAM on a wishbone classic slave port, registered ack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ls_byte_ram #(
    parameter int mem_aw = 12
) (
    input  logic                  ctl,
    input  logic                  rst_n,
    input  ls_bus_pkg::wb_req_t   req,
    output ls_bus_pkg::wb_rsp_t   rsp
);

    logic [7:0]        mem [2**mem_aw];
    logic [mem_aw-1:0] idx;                  // upper address bits dropped
    logic              ack_q;
    logic [7:0]        dat_q;
    logic              access;               // new beat seen this cycle

    assign idx    = req.adr[mem_aw-1:0];
    assign access = req.cyc & req.stb & ~ack_q;

    always_ff @(posedge ctl or negedge rst_n) begin
        if (!rst_n)
            ack_q <= 1'b0;
        else
            ack_q <= access;                 // one cycle later, one cycle long
    end

    always_ff @(posedge ctl) begin
        if (access) begin
            if (req.we)
                mem[idx] <= req.dat_w;
            dat_q <= mem[idx];
        end
    end

    assign rsp.ack   = ack_q;
    assign rsp.dat_r = dat_q;

endmodule

`default_nettype wire

/* ls_byte_lane.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte lanes: picks store bytes, merges load bytes and forms
// the new top of stack with sign or zero extension
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ls_byte_lane (
    input  logic                     ctl,
    input  logic                     rst_n,
    input  logic                     start,
    input  ls_types_pkg::ls_op_e     op,
    input  ls_types_pkg::ls_cmd_t    cmd,
    input  logic                     ack,
    input  logic [7:0]               dat_r,
    input  logic [2:0]               remaining,
    output logic [7:0]               dat_w,
    output ls_types_pkg::ls_result_t result
);

    ls_types_pkg::word_t tos_q;              // store data
    ls_types_pkg::word_t nos_q;              // tos after a pop
    ls_types_pkg::word_t merge_q;            // load bytes so far
    ls_types_pkg::word_t merged;             // including this beat
    ls_types_pkg::word_t final_tos;

    // byte r-1 of tos goes out on the beat with r left
    always_comb begin
        case (remaining)
            3'd4:    dat_w = tos_q[31:24];
            3'd3:    dat_w = tos_q[23:16];
            3'd2:    dat_w = tos_q[15:8];
            default: dat_w = tos_q[7:0];
        endcase
    end

    assign merged = {merge_q[23:0], dat_r};

    always_comb begin
        case (op)
            ls_types_pkg::op_iaload: final_tos = merged;
            ls_types_pkg::op_saload: final_tos = {{16{merged[15]}}, merged[15:0]};
            ls_types_pkg::op_baload: final_tos = {{24{merged[7]}}, merged[7:0]};
            ls_types_pkg::op_get:    final_tos = {24'd0, merged[7:0]};   // unsigned
            default:                 final_tos = nos_q;                  // stack pops
        endcase
    end

    always_ff @(posedge ctl) begin
        if (start) begin
            tos_q <= cmd.tos;
            nos_q <= cmd.nos;
        end
        if (ack)
            merge_q <= merged;               // shift in, msb first
    end

    // held from the final ack until the next command's final ack
    always_ff @(posedge ctl or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (ack && remaining == 3'd1) begin
            result.tos <= final_tos;
            result.op  <= op;
        end
    end

endmodule

`default_nettype wire

/* ls_addr_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus address register and the input/output buffer pointers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ls_addr_unit #(
    parameter ls_types_pkg::addr_t tib_base  = 'h400,
    parameter ls_types_pkg::addr_t obuf_base = 'h500
) (
    input  logic                  ctl,
    input  logic                  rst_n,
    input  logic                  start,
    input  ls_types_pkg::ls_op_e  op,
    input  ls_types_pkg::ls_cmd_t cmd,
    input  logic                  ack,
    input  logic                  done,
    output ls_types_pkg::addr_t   adr
);

    localparam int aw = $bits(ls_types_pkg::addr_t);

    ls_types_pkg::addr_t adr_q;
    ls_types_pkg::addr_t ibuf;               // next get address
    ls_types_pkg::addr_t obuf;               // next put address
    ls_types_pkg::addr_t src;                // start address for op

    always_comb begin
        case (op)
            ls_types_pkg::op_iaload,
            ls_types_pkg::op_saload,
            ls_types_pkg::op_baload:  src = cmd.tos[aw-1:0];   // loads from tos
            ls_types_pkg::op_get:     src = ibuf;
            ls_types_pkg::op_put:     src = obuf;
            default:                  src = cmd.nos[aw-1:0];   // stores to nos
        endcase
    end

    assign adr = adr_q;

    always_ff @(posedge ctl or negedge rst_n) begin
        if (!rst_n) begin
            adr_q <= '0;
            ibuf  <= tib_base;
            obuf  <= obuf_base;
        end else begin
            if (start) begin
                adr_q <= src;
            end else if (ack) begin
                adr_q <= adr_q + 1'b1;       // next byte, big-endian order
            end
            if (done && op == ls_types_pkg::op_get)
                ibuf <= ibuf + 1'b1;
            if (done && op == ls_types_pkg::op_put)
                obuf <= obuf + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* ls_beat_counter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// counts the byte beats still to run for one command
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ls_beat_counter (
    input  logic                 ctl,
    input  logic                 rst_n,
    input  logic                 start,
    input  ls_types_pkg::ls_op_e op,
    input  logic                 ack,
    output logic [2:0]           remaining,
    output logic                 last
);

    logic [2:0] load_cnt;                    // beats for this op

    always_comb begin
        case (op)
            ls_types_pkg::op_iaload, ls_types_pkg::op_iastore: load_cnt = 3'd4;
            ls_types_pkg::op_saload, ls_types_pkg::op_sastore: load_cnt = 3'd2;
            default:                                            load_cnt = 3'd1;
        endcase
    end

    assign last = (remaining == 3'd1);

    always_ff @(posedge ctl or negedge rst_n) begin
        if (!rst_n) begin
            remaining <= 3'd0;
        end else if (start) begin
            remaining <= load_cnt;
        end else if (ack && remaining != 3'd0) begin
            remaining <= remaining - 3'd1;   // one beat retired
        end
    end

endmodule

`default_nettype wire

/* ls_sequencer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load/store sequencer: takes a command, runs the byte beats
// on the bus and pulses done when the last beat is back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ls_sequencer (
    input  logic                 ctl,
    input  logic                 rst_n,
    input  logic                 cmd_valid,
    input  ls_types_pkg::ls_cmd_t cmd,
    output logic                 cmd_ready,
    input  logic                 ack,        // beat done
    input  logic                 last,       // final beat in flight
    output logic                 cyc,
    output logic                 stb,
    output logic                 we,
    output logic                 start,      // acceptance cycle
    output ls_types_pkg::ls_op_e op,
    output logic                 done
);

    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_strobe = 2'd1,                    // stb high until ack
        st_gap    = 2'd2                     // stb low after ack
    } state_e;

    state_e               state;
    ls_types_pkg::ls_op_e op_q;              // op of the running command
    logic                 final_q;           // last beat was acked

    function automatic logic is_write(input ls_types_pkg::ls_op_e o);
        is_write = (o == ls_types_pkg::op_iastore) || (o == ls_types_pkg::op_sastore) ||
                   (o == ls_types_pkg::op_bastore) || (o == ls_types_pkg::op_put);
    endfunction

    assign cmd_ready = (state == st_idle);
    assign start     = cmd_ready & cmd_valid;
    assign op        = start ? cmd.op : op_q;   // live op while accepting
    assign cyc       = (state != st_idle) & ~done;   // held across the beats
    assign stb       = (state == st_strobe);
    assign we        = cyc & is_write(op_q);
    assign done      = (state == st_gap) & final_q;

    always_ff @(posedge ctl or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            op_q    <= ls_types_pkg::op_iaload;
            final_q <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        op_q  <= cmd.op;
                        state <= st_strobe;
                    end
                end
                st_strobe: begin
                    if (ack) begin
                        final_q <= last;     // remember whether that was the end
                        state   <= st_gap;
                    end
                end
                st_gap: begin
                    state   <= final_q ? st_idle : st_strobe;
                    final_q <= 1'b0;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* ls_bus_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wishbone classic byte bus, master request and slave reply
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package ls_bus_pkg;

    // master to slave
    typedef struct packed {
        logic                cyc;            // bus cycle in progress
        logic                stb;            // beat strobe
        logic                we;             // write beat
        ls_types_pkg::addr_t adr;            // byte address
        logic [7:0]          dat_w;          // store byte
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic       ack;                     // single-cycle beat end
        logic [7:0] dat_r;                   // load byte
    } wb_rsp_t;

endpackage

`default_nettype wire

/* ls_types_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load/store unit types: stack words, byte addresses,
// operation codes and the command and result records
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package ls_types_pkg;

    typedef logic [31:0] word_t;             // stack value
    typedef logic [16:0] addr_t;             // 128K byte space

    typedef enum logic [2:0] {
        op_iaload  = 3'd0,                   // 4 bytes, big-endian
        op_saload  = 3'd1,                   // 2 bytes, sign-extended
        op_baload  = 3'd2,                   // 1 byte, sign-extended
        op_iastore = 3'd3,
        op_sastore = 3'd4,
        op_bastore = 3'd5,
        op_get     = 3'd6,                   // input buffer read
        op_put     = 3'd7                    // output buffer write
    } ls_op_e;

    // one host command
    typedef struct packed {
        ls_op_e op;
        word_t  tos;                         // top of stack
        word_t  nos;                         // next on stack
    } ls_cmd_t;

    // new top of stack, tagged with its op
    typedef struct packed {
        word_t  tos;
        ls_op_e op;
    } ls_result_t;

endpackage

`default_nettype wire
